//--- design/fp_config.svh
// single-precision format parameters
// shared by the format and pipeline packages and both stages
`ifndef FP_CONFIG_SVH
`define FP_CONFIG_SVH

// exponent field width
`define FP_EXP_W 8

// fraction field width, hidden bit not included
`define FP_FRAC_W 23

// exponent bias
`define FP_BIAS 127

// guard, round and sticky bits kept below the lsb
`define FP_GRS_W 3

`endif

//--- design/fp_format_pkg.sv
// ieee-754 single-precision number format
// float layout, rounding modes, exception flags and the canonical nan
`default_nettype none

package fp_format_pkg;

`include "fp_config.svh"

   typedef struct packed {
      logic                  sign;
      logic [`FP_EXP_W-1:0]  exp;
      logic [`FP_FRAC_W-1:0] frac;
   } float_t;

   // frm encodings, unlisted values behave as RNE
   typedef enum logic [2:0] {
      RNE = 3'd0,
      RTZ = 3'd1,
      RDN = 3'd2,
      RUP = 3'd3
   } rnd_mode_t;

   typedef struct packed {
      logic invalid;
      logic overflow;
      logic underflow;
      logic inexact;
   } fp_flags_t;

   // exponent value used by inf and nan
   localparam logic [`FP_EXP_W-1:0] EXP_ALL1 = '1;

   localparam logic [31:0] QNAN = 32'h7FC0_0000;

endpackage

`default_nettype wire

//--- design/fp_pipe_pkg.sv
// add/sub pipeline transactions
// request, aligned intermediate and packed result
`default_nettype none

package fp_pipe_pkg;

`include "fp_config.svh"

   import fp_format_pkg::*;

   // carry + hidden bit + fraction + grs
   localparam int MANT_W = `FP_FRAC_W + 2 + `FP_GRS_W;

   typedef struct packed {
      float_t    a;
      float_t    b;
      logic      sub;
      rnd_mode_t frm;
   } op_req_t;

   typedef struct packed {
      logic                 sign;
      logic [`FP_EXP_W-1:0] exp;
      logic [MANT_W-1:0]    mant;
      rnd_mode_t            frm;
      // special_val is the final answer
      logic                 special;
      float_t               special_val;
      fp_flags_t            special_flags;
   } aligned_op_t;

   typedef struct packed {
      float_t    value;
      fp_flags_t flags;
   } fp_result_t;

endpackage

`default_nettype wire

//--- design/fp_align_stage.sv
// add/sub align stage: unpacks, resolves special cases, aligns and
// adds or subtracts the mantissas into a registered aligned transaction
`timescale 1ns/1ps
`default_nettype none

`include "fp_config.svh"

module fp_align_stage (
   input  logic                     clk,
   input  logic                     arst_n,
   input  logic                     in_valid,
   output logic                     in_ready,
   input  fp_pipe_pkg::op_req_t     in_req,
   output logic                     out_valid,
   input  logic                     out_ready,
   output fp_pipe_pkg::aligned_op_t out_op
);
   import fp_format_pkg::*;
   import fp_pipe_pkg::*;

   // hidden bit + fraction + grs
   localparam int EXT_W = MANT_W - 1;

   float_t               a;
   float_t               b;
   float_t               lg;
   float_t               sm;
   logic                 a_zero;
   logic                 b_zero;
   logic                 a_inf;
   logic                 b_inf;
   logic                 a_nan;
   logic                 b_nan;
   logic                 any_snan;
   logic                 eff_sub;
   logic                 swap;
   logic [`FP_FRAC_W:0]  lg_sig;
   logic [`FP_FRAC_W:0]  sm_sig;
   logic [EXT_W-1:0]     lg_ext;
   logic [EXT_W-1:0]     sm_ext;
   logic [EXT_W-1:0]     sm_shift;
   logic [EXT_W-1:0]     keep_mask;
   logic [`FP_EXP_W-1:0] exp_diff;
   logic                 sticky;
   aligned_op_t          op_d;
   logic                 ready_en;

   always_comb begin
      a = in_req.a;
      b = in_req.b;
      // subtraction is addition with b negated
      b.sign = in_req.b.sign ^ in_req.sub;

      // subnormals count as zero
      a_zero   = (a.exp == '0);
      b_zero   = (b.exp == '0);
      a_inf    = (a.exp == EXP_ALL1) && (a.frac == '0);
      b_inf    = (b.exp == EXP_ALL1) && (b.frac == '0);
      a_nan    = (a.exp == EXP_ALL1) && (a.frac != '0);
      b_nan    = (b.exp == EXP_ALL1) && (b.frac != '0);
      any_snan = (a_nan && !a.frac[`FP_FRAC_W-1]) || (b_nan && !b.frac[`FP_FRAC_W-1]);
      eff_sub  = a.sign ^ b.sign;

      // larger magnitude goes first
      swap   = {b.exp, b.frac} > {a.exp, a.frac};
      lg     = swap ? b : a;
      sm     = swap ? a : b;
      lg_sig = ((swap ? b_zero : a_zero)) ? '0 : {1'b1, lg.frac};
      sm_sig = ((swap ? a_zero : b_zero)) ? '0 : {1'b1, sm.frac};
      lg_ext = {lg_sig, {`FP_GRS_W{1'b0}}};
      sm_ext = {sm_sig, {`FP_GRS_W{1'b0}}};

      exp_diff  = lg.exp - sm.exp;
      keep_mask = '1;
      if (exp_diff >= EXT_W) begin
         sm_shift = '0;
         sticky   = |sm_ext;
      end else begin
         sm_shift  = sm_ext >> exp_diff;
         keep_mask = {EXT_W{1'b1}} << exp_diff;
         sticky    = |(sm_ext & ~keep_mask);
      end
      // bits shifted out collapse into the sticky lsb
      sm_shift[0] = sm_shift[0] | sticky;

      op_d.sign          = lg.sign;
      op_d.exp           = lg.exp;
      op_d.mant          = eff_sub ? ({1'b0, lg_ext} - {1'b0, sm_shift})
                                   : ({1'b0, lg_ext} + {1'b0, sm_shift});
      op_d.frm           = in_req.frm;
      op_d.special       = 1'b0;
      op_d.special_val   = '0;
      op_d.special_flags = '0;

      if (a_nan || b_nan) begin
         op_d.special               = 1'b1;
         op_d.special_val           = QNAN;
         op_d.special_flags.invalid = any_snan;
      end else if (a_inf && b_inf && eff_sub) begin
         // inf - inf
         op_d.special               = 1'b1;
         op_d.special_val           = QNAN;
         op_d.special_flags.invalid = 1'b1;
      end else if (a_inf) begin
         op_d.special     = 1'b1;
         op_d.special_val = a;
      end else if (b_inf) begin
         op_d.special     = 1'b1;
         op_d.special_val = b;
      end else if (a_zero && b_zero) begin
         // opposite-signed zeros give +0, or -0 when rounding down
         op_d.special          = 1'b1;
         op_d.special_val.sign = (a.sign & b.sign) |
                                 ((in_req.frm == RDN) & (a.sign | b.sign));
      end
   end

   // held low until the first edge after reset
   assign in_ready = ready_en & (~out_valid | out_ready);

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         ready_en  <= 1'b0;
         out_valid <= 1'b0;
      end else begin
         ready_en <= 1'b1;
         if (in_ready) begin
            out_valid <= in_valid;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (in_valid && in_ready) begin
         out_op <= op_d;
      end
   end

endmodule

`default_nettype wire

//--- design/fp_skid_buffer.sv
// two-entry valid/ready skid buffer with registered outputs and ready
`timescale 1ns/1ps
`default_nettype none

module fp_skid_buffer #(
   parameter type payload_t = logic [31:0]
) (
   input  logic     clk,
   input  logic     arst_n,
   input  logic     in_valid,
   output logic     in_ready,
   input  payload_t in_data,
   output logic     out_valid,
   input  logic     out_ready,
   output payload_t out_data
);

   logic     skid_valid;
   payload_t skid_data;
   logic     ready_q;
   logic     in_fire;
   logic     out_free;
   logic     skid_load;
   logic     skid_valid_d;

   assign in_ready = ready_q;
   assign in_fire  = in_valid & ready_q;
   // main register empties or drains this cycle
   assign out_free = ~out_valid | out_ready;

   // main stalled, so the incoming item parks in the skid entry
   assign skid_load    = in_fire & ~out_free;
   assign skid_valid_d = skid_load | (skid_valid & ~out_free);

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         out_valid  <= 1'b0;
         skid_valid <= 1'b0;
         ready_q    <= 1'b0;
      end else begin
         if (out_free) begin
            out_valid <= skid_valid | in_fire;
         end
         skid_valid <= skid_valid_d;
         ready_q    <= ~skid_valid_d;
      end
   end

   always_ff @(posedge clk) begin
      // skid entry is older, so it drains first
      if (out_free && (skid_valid || in_fire)) begin
         out_data <= skid_valid ? skid_data : in_data;
      end
      if (skid_load) begin
         skid_data <= in_data;
      end
   end

endmodule

`default_nettype wire

//--- design/fp_round_stage.sv
// add/sub round stage: normalizes, rounds per frm and packs
// the result with its exception flags, fully combinational
`timescale 1ns/1ps
`default_nettype none

`include "fp_config.svh"

module fp_round_stage (
   input  logic                     in_valid,
   output logic                     in_ready,
   input  fp_pipe_pkg::aligned_op_t in_op,
   output logic                     out_valid,
   input  logic                     out_ready,
   output fp_pipe_pkg::fp_result_t  out_res
);
   import fp_format_pkg::*;
   import fp_pipe_pkg::*;

   // hidden bit + fraction + grs after normalization
   localparam int NORM_W  = MANT_W - 1;
   localparam int LZ_W    = $clog2(NORM_W + 1);
   // largest finite biased exponent
   localparam int EXP_MAX = 2 * `FP_BIAS;

   logic [LZ_W-1:0]         lz;
   logic [NORM_W-1:0]       norm;
   logic signed [`FP_EXP_W+1:0] exp_n;
   logic signed [`FP_EXP_W+1:0] exp_r;
   logic [`FP_FRAC_W+1:0]   rounded;
   logic                    lsb;
   logic                    guard;
   logic                    rest;
   logic                    inexact;
   logic                    round_up;
   logic                    to_inf;

   // nothing is held here
   assign in_ready  = out_ready;
   assign out_valid = in_valid;

   // leading zeros below the carry bit, highest set bit wins
   always_comb begin
      lz = LZ_W'(NORM_W);
      for (int i = 0; i < NORM_W; i++) begin
         if (in_op.mant[i]) begin
            lz = LZ_W'(NORM_W - 1 - i);
         end
      end
   end

   always_comb begin
      if (in_op.mant[MANT_W-1]) begin
         // carry out, shift right by one and keep the sticky
         norm  = {in_op.mant[MANT_W-1:2], in_op.mant[1] | in_op.mant[0]};
         exp_n = $signed({2'b00, in_op.exp}) + 10'sd1;
      end else begin
         norm  = in_op.mant[NORM_W-1:0] << lz;
         exp_n = $signed({2'b00, in_op.exp}) - $signed({{(`FP_EXP_W + 2 - LZ_W){1'b0}}, lz});
      end

      lsb     = norm[`FP_GRS_W];
      guard   = norm[`FP_GRS_W-1];
      rest    = |norm[`FP_GRS_W-2:0];
      inexact = guard | rest;

      case (in_op.frm)
         RTZ:     round_up = 1'b0;
         RDN:     round_up = in_op.sign & inexact;
         RUP:     round_up = ~in_op.sign & inexact;
         // RNE and unlisted encodings, ties go to even
         default: round_up = guard & (rest | lsb);
      endcase

      rounded = {1'b0, norm[NORM_W-1:`FP_GRS_W]} + {{(`FP_FRAC_W + 1){1'b0}}, round_up};
      // mantissa carry bumps the exponent, fraction is already zero
      exp_r = exp_n + $signed({{(`FP_EXP_W + 1){1'b0}}, rounded[`FP_FRAC_W+1]});

      // overflow goes to inf only when rounding away from zero
      case (in_op.frm)
         RTZ:     to_inf = 1'b0;
         RDN:     to_inf = in_op.sign;
         RUP:     to_inf = ~in_op.sign;
         default: to_inf = 1'b1;
      endcase

      out_res.value.sign    = in_op.sign;
      out_res.value.exp     = exp_r[`FP_EXP_W-1:0];
      out_res.value.frac    = rounded[`FP_FRAC_W-1:0];
      out_res.flags         = '0;
      out_res.flags.inexact = inexact;

      if (in_op.special) begin
         out_res.value = in_op.special_val;
         out_res.flags = in_op.special_flags;
      end else if (in_op.mant == '0) begin
         // exact cancellation
         out_res.value      = '0;
         out_res.value.sign = (in_op.frm == RDN);
         out_res.flags      = '0;
      end else if (exp_r > EXP_MAX) begin
         out_res.value.exp      = to_inf ? EXP_ALL1 : (EXP_ALL1 - 1'b1);
         out_res.value.frac     = to_inf ? '0 : '1;
         out_res.flags.overflow = 1'b1;
         out_res.flags.inexact  = 1'b1;
      end else if (exp_r < 1) begin
         // flush to signed zero
         out_res.value.exp       = '0;
         out_res.value.frac      = '0;
         out_res.flags.underflow = 1'b1;
         out_res.flags.inexact   = 1'b1;
      end
   end

endmodule

`default_nettype wire

//--- design/fp_addsub_top.sv
// pipelined single-precision adder/subtractor
// align stage, skid buffer, round stage, output skid buffer
`timescale 1ns/1ps
`default_nettype none

module fp_addsub_top (
   input  logic                    clk,
   input  logic                    arst_n,
   input  logic                    in_valid,
   output logic                    in_ready,
   input  fp_pipe_pkg::op_req_t    in_req,
   output logic                    out_valid,
   input  logic                    out_ready,
   output fp_pipe_pkg::fp_result_t out_res
);
   import fp_pipe_pkg::*;

   logic        al_valid;
   logic        al_ready;
   aligned_op_t al_op;
   logic        mid_valid;
   logic        mid_ready;
   aligned_op_t mid_op;
   logic        rnd_valid;
   logic        rnd_ready;
   fp_result_t  rnd_res;

   fp_align_stage align_i (
      .clk       (clk),
      .arst_n    (arst_n),
      .in_valid  (in_valid),
      .in_ready  (in_ready),
      .in_req    (in_req),
      .out_valid (al_valid),
      .out_ready (al_ready),
      .out_op    (al_op)
   );

   fp_skid_buffer #(
      .payload_t (aligned_op_t)
   ) mid_buf_i (
      .clk       (clk),
      .arst_n    (arst_n),
      .in_valid  (al_valid),
      .in_ready  (al_ready),
      .in_data   (al_op),
      .out_valid (mid_valid),
      .out_ready (mid_ready),
      .out_data  (mid_op)
   );

   fp_round_stage round_i (
      .in_valid  (mid_valid),
      .in_ready  (mid_ready),
      .in_op     (mid_op),
      .out_valid (rnd_valid),
      .out_ready (rnd_ready),
      .out_res   (rnd_res)
   );

   // absorbs output back-pressure
   fp_skid_buffer #(
      .payload_t (fp_result_t)
   ) out_buf_i (
      .clk       (clk),
      .arst_n    (arst_n),
      .in_valid  (rnd_valid),
      .in_ready  (rnd_ready),
      .in_data   (rnd_res),
      .out_valid (out_valid),
      .out_ready (out_ready),
      .out_data  (out_res)
   );

endmodule

`default_nettype wire

//--- tests/fp_addsub_assertions.sv
// handshake assertions for the add/sub pipeline, bound to the top level
`timescale 1ns/1ps
`default_nettype none

module fp_addsub_assertions (
   input logic                    clk,
   input logic                    arst_n,
   input logic                    in_valid,
   input logic                    in_ready,
   input logic                    out_valid,
   input logic                    out_ready,
   input fp_pipe_pkg::fp_result_t out_res
);

   int unsigned fail_count = 0;

   // a stalled result stays valid and unchanged
   out_hold_a : assert property (
      @(posedge clk) disable iff (!arst_n)
      out_valid && !out_ready |=> out_valid && $stable(out_res)
   ) else begin
      $error("out_res dropped or changed while out_ready was low");
      fail_count++;
   end

   reset_quiet_a : assert property (
      @(posedge clk) !arst_n |-> !in_ready && !out_valid
   ) else begin
      $error("in_ready or out_valid high during reset");
      fail_count++;
   end

   in_hold_a : assert property (
      @(posedge clk) disable iff (!arst_n)
      in_valid && !in_ready |=> in_valid
   ) else begin
      $error("in_valid fell before its transfer");
      fail_count++;
   end

endmodule

bind fp_addsub_top fp_addsub_assertions assert_i (
   .clk       (clk),
   .arst_n    (arst_n),
   .in_valid  (in_valid),
   .in_ready  (in_ready),
   .out_valid (out_valid),
   .out_ready (out_ready),
   .out_res   (out_res)
);

`default_nettype wire

//--- tests/fp_addsub_checker.sv
// in-order result checker for the add/sub pipeline
// keeps expected results in a queue and compares on each output transfer
`timescale 1ns/1ps
`default_nettype none

module fp_addsub_checker (
   input logic                    clk,
   input logic                    arst_n,
   input logic                    out_valid,
   input logic                    out_ready,
   input fp_pipe_pkg::fp_result_t out_res
);
   import fp_pipe_pkg::*;

   fp_result_t  expected_q [$];
   fp_result_t  exp_res;
   int unsigned value_errs;
   int unsigned flag_errs;
   int unsigned other_errs;
   int unsigned num_received;

   initial begin
      value_errs   = 0;
      flag_errs    = 0;
      other_errs   = 0;
      num_received = 0;
   end

   task automatic expect_result(input logic [31:0] value, input logic [3:0] flags);
      fp_result_t item;
      item = {value, flags};
      expected_q.push_back(item);
   endtask

   task automatic report_missing();
      if (expected_q.size() != 0) begin
         other_errs += expected_q.size();
         $display("%0d expected results never arrived", expected_q.size());
      end
   endtask

   // outputs are registered, so edge sampling sees the settled values
   always @(posedge clk) begin
      if (arst_n && out_valid && out_ready) begin
         num_received++;
         if (expected_q.size() == 0) begin
            other_errs++;
            $display("a result arrived with nothing expected: value %h, flags %h",
                     out_res.value, out_res.flags);
         end else begin
            exp_res = expected_q.pop_front();
            if (out_res.value !== exp_res.value) begin
               value_errs++;
               $display("** Error: out_res.value expected %h, got %h",
                        exp_res.value, out_res.value);
            end
            if (out_res.flags !== exp_res.flags) begin
               flag_errs++;
               $display("** Error: out_res.flags expected %h, got %h",
                        exp_res.flags, out_res.flags);
            end
         end
      end
   end

endmodule

`default_nettype wire

//--- tests/fp_addsub_tb.sv
// testbench for the pipelined single-precision adder/subtractor
// drives a table of hand-worked operations under random output back-pressure
`timescale 1ns/1ps
`default_nettype none

module fp_addsub_tb;
   import fp_pipe_pkg::*;

   localparam int NUM_VECS   = 18;
   localparam int MAX_CYCLES = NUM_VECS * 8 + 50;

   // a, b, sub, frm, expected value, expected flags {inv, ovf, unf, inx}
   typedef struct packed {
      logic [31:0] a;
      logic [31:0] b;
      logic        sub;
      logic [2:0]  frm;
      logic [31:0] value;
      logic [3:0]  flags;
   } vector_t;

   logic        clk = 1'b0;
   logic        arst_n;
   logic        in_valid;
   logic        in_ready;
   op_req_t     in_req;
   logic        out_valid;
   logic        out_ready;
   fp_result_t  out_res;
   vector_t     vectors [NUM_VECS];
   integer      seed;
   int unsigned cycle_count;
   int unsigned tb_errs;
   int unsigned total_errs;

   fp_addsub_top dut_i (
      .clk       (clk),
      .arst_n    (arst_n),
      .in_valid  (in_valid),
      .in_ready  (in_ready),
      .in_req    (in_req),
      .out_valid (out_valid),
      .out_ready (out_ready),
      .out_res   (out_res)
   );

   fp_addsub_checker chk_i (
      .clk       (clk),
      .arst_n    (arst_n),
      .out_valid (out_valid),
      .out_ready (out_ready),
      .out_res   (out_res)
   );

   always #10 clk = ~clk;

   task automatic load_vectors();
      // exact sums and cancellation
      vectors[0]  = {32'h3F800000, 32'h40000000, 1'b0, 3'd0, 32'h40400000, 4'h0};
      vectors[1]  = {32'h3F800000, 32'h3F800000, 1'b1, 3'd0, 32'h00000000, 4'h0};
      vectors[2]  = {32'h3F800000, 32'h3F800000, 1'b1, 3'd2, 32'h80000000, 4'h0};
      vectors[3]  = {32'h3F800001, 32'h3F800000, 1'b1, 3'd0, 32'h34000000, 4'h0};
      // rounding, ties and the four modes
      vectors[4]  = {32'h3F800000, 32'h33800000, 1'b0, 3'd0, 32'h3F800000, 4'h1};
      vectors[5]  = {32'h3F800001, 32'h33800000, 1'b0, 3'd0, 32'h3F800002, 4'h1};
      vectors[6]  = {32'h3F800000, 32'h33C00000, 1'b0, 3'd0, 32'h3F800001, 4'h1};
      vectors[7]  = {32'h3F800000, 32'hB3C00000, 1'b1, 3'd1, 32'h3F800000, 4'h1};
      vectors[8]  = {32'h3F800000, 32'h33800000, 1'b0, 3'd3, 32'h3F800001, 4'h1};
      vectors[9]  = {32'hBF800000, 32'hB3800000, 1'b0, 3'd2, 32'hBF800001, 4'h1};
      // overflow and flush to zero
      vectors[10] = {32'h7F7FFFFF, 32'h7F7FFFFF, 1'b0, 3'd0, 32'h7F800000, 4'h5};
      vectors[11] = {32'h7F7FFFFF, 32'h7F7FFFFF, 1'b0, 3'd1, 32'h7F7FFFFF, 4'h5};
      vectors[12] = {32'h80800001, 32'h80800000, 1'b1, 3'd0, 32'h80000000, 4'h3};
      // nan, inf and subnormal inputs
      vectors[13] = {32'h7F800000, 32'h7F800000, 1'b1, 3'd0, 32'h7FC00000, 4'h8};
      vectors[14] = {32'h7F800001, 32'h3F800000, 1'b0, 3'd0, 32'h7FC00000, 4'h8};
      vectors[15] = {32'h7FC00001, 32'h3F800000, 1'b0, 3'd0, 32'h7FC00000, 4'h0};
      vectors[16] = {32'h7F800000, 32'h3F800000, 1'b0, 3'd0, 32'h7F800000, 4'h0};
      vectors[17] = {32'h00000001, 32'h3F800000, 1'b0, 3'd0, 32'h3F800000, 4'h0};
   endtask

   // out_ready high on about 70% of cycles
   initial begin
      seed      = 24545;
      out_ready = 1'b0;
      @(posedge arst_n);
      forever begin
         @(posedge clk);
         #1;
         out_ready = ($unsigned($random(seed)) % 100) < 70;
      end
   end

   initial begin
      cycle_count = 0;
      while (cycle_count < MAX_CYCLES) begin
         @(posedge clk);
         cycle_count++;
      end
      $display("timeout: run stopped after %0d cycles", cycle_count);
      chk_i.report_missing();
      $display("TESTS FAILED");
      $finish;
   end

   initial begin
      tb_errs  = 0;
      arst_n   = 1'b0;
      in_valid = 1'b0;
      in_req   = '0;
      load_vectors();
      repeat (3) @(posedge clk);
      #1;
      arst_n = 1'b1;
      @(posedge clk);
      #1;

      for (int i = 0; i < NUM_VECS; i++) begin
         in_valid = 1'b1;
         in_req   = {vectors[i].a, vectors[i].b, vectors[i].sub, vectors[i].frm};
         if (i == 0 && !in_ready) begin
            tb_errs++;
            $display("in_ready still low on the first cycle after reset");
         end
         // in_ready only moves on clock edges
         while (!in_ready) begin
            @(posedge clk);
            #1;
         end
         chk_i.expect_result(vectors[i].value, vectors[i].flags);
         @(posedge clk);
         #1;
      end
      in_valid = 1'b0;

      while (chk_i.num_received < NUM_VECS) begin
         @(posedge clk);
      end
      // catch any stray extra result
      repeat (5) @(posedge clk);
      chk_i.report_missing();

      total_errs = chk_i.value_errs + chk_i.flag_errs + chk_i.other_errs +
                   dut_i.assert_i.fail_count + tb_errs;
      $display("errors: value %0d, flags %0d, sequence %0d, assertion %0d, stimulus %0d",
               chk_i.value_errs, chk_i.flag_errs, chk_i.other_errs,
               dut_i.assert_i.fail_count, tb_errs);
      if (total_errs == 0) begin
         $display("TESTS PASSED");
      end else begin
         $display("TESTS FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire

//--- compile.f
+incdir+design
design/fp_format_pkg.sv
design/fp_pipe_pkg.sv
design/fp_align_stage.sv
design/fp_skid_buffer.sv
design/fp_round_stage.sv
design/fp_addsub_top.sv
tests/fp_addsub_assertions.sv
tests/fp_addsub_checker.sv
tests/fp_addsub_tb.sv
